// File: Makefile
TOOL     = verilator
VFLAGS   = --binary --assert -j 0
TOP      = tb_vector_lane
FILELIST = src.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG) || ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: source/execute_wb.sv
`timescale 1ns/1ps
`default_nettype none

module execute_wb import lane_cfg_pkg::*; import lane_isa_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              head_valid_i,
   input  opnd_entry_t       head_entry_i,
   output logic              pop_o,
   lane_wb_if.exec           wb,
   output logic              store_valid_o,
   output logic [DATA_W-1:0] store_data_o,
   input  logic              store_ready_i
);

   logic              is_store;
   logic              write_ok;
   logic [DATA_W-1:0] alu_res;
   logic [DATA_W-1:0] elem_res;
   logic [DATA_W-1:0] placed_res;
   logic [BE_W-1:0]   placed_be;

   assign is_store = (head_entry_i.op == OP_STORE);

   // Masked ops only write where the mask bit is set
   assign write_ok = !head_entry_i.masked || head_entry_i.mask_bit;

   //////////////////////////////////////////////////
   // ALU and element placement
   //////////////////////////////////////////////////

   always_comb begin
      case (head_entry_i.op)
         OP_ADD:  alu_res = head_entry_i.a + head_entry_i.b;
         OP_SUB:  alu_res = head_entry_i.a - head_entry_i.b;
         OP_AND:  alu_res = head_entry_i.a & head_entry_i.b;
         OP_OR:   alu_res = head_entry_i.a | head_entry_i.b;
         OP_XOR:  alu_res = head_entry_i.a ^ head_entry_i.b;
         OP_LOAD: alu_res = head_entry_i.ld_data;
         default: alu_res = '0;
      endcase
   end

   // Truncate to SEW, then move into the element slot
   always_comb begin
      case (head_entry_i.sew)
         SEW8: begin
            elem_res   = DATA_W'(alu_res[7:0]);
            placed_res = elem_res << (head_entry_i.el * 8);
            placed_be  = BE_W'(1) << head_entry_i.el;
         end
         SEW16: begin
            elem_res   = DATA_W'(alu_res[15:0]);
            placed_res = elem_res << (head_entry_i.el[0] * 16);
            placed_be  = BE_W'(2'b11) << (head_entry_i.el[0] * 2);
         end
         SEW32: begin
            elem_res   = alu_res;
            placed_res = alu_res;
            placed_be  = '1;
         end
         default: begin
            elem_res   = '0;
            placed_res = '0;
            placed_be  = '0;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Write-back, retire and store port
   //////////////////////////////////////////////////

   assign wb.retire    = head_valid_i && !is_store;
   assign wb.wr_en     = wb.retire && (head_entry_i.op != OP_MSEQ) && write_ok;
   assign wb.wr_addr   = head_entry_i.vd;
   assign wb.wr_be     = placed_be;
   assign wb.wr_data   = placed_res;
   assign wb.mask_wen  = wb.retire && (head_entry_i.op == OP_MSEQ) && write_ok;
   assign wb.mask_data = (head_entry_i.a == head_entry_i.b);

   assign store_valid_o = head_valid_i && is_store;
   assign store_data_o  = head_entry_i.b;
   assign pop_o         = head_valid_i && (!is_store || store_ready_i);

   a_be_aligned : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      wb.wr_en |-> ((head_entry_i.sew == SEW8  && $onehot(wb.wr_be)) ||
                    (head_entry_i.sew == SEW16 && (wb.wr_be == 4'b0011 || wb.wr_be == 4'b1100)) ||
                    (head_entry_i.sew == SEW32 && wb.wr_be == 4'b1111))
   ) else $error("byte enables %b do not match SEW", wb.wr_be);

   // A stalled store keeps its value until the consumer takes it
   a_store_hold : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      (store_valid_o && !store_ready_i) |=> (store_valid_o && $stable(store_data_o))
   ) else $error("store data changed while stalled");

endmodule

`default_nettype wire

// File: source/lane_cfg_pkg.sv
`default_nettype none

package lane_cfg_pkg;

   // Element word and register file geometry
   localparam int DATA_W     = 32;
   localparam int NUM_REGS   = 32;
   localparam int REG_ADDR_W = 5;

   // Byte enables per word and element index within a word
   localparam int BE_W = 4;
   localparam int EL_W = 2;

   // Operand FIFO depth unless the top level overrides it
   localparam int DEF_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// File: source/lane_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Read side of the register and mask files
interface lane_rd_if import lane_cfg_pkg::*; ();

   logic [REG_ADDR_W-1:0] rd_addr1;
   logic [REG_ADDR_W-1:0] rd_addr2;
   logic [REG_ADDR_W-1:0] mask_addr;
   logic [DATA_W-1:0]     rd_data1;
   logic [DATA_W-1:0]     rd_data2;
   logic                  mask_bit;

   modport fetch (output rd_addr1, rd_addr2, mask_addr,
                  input  rd_data1, rd_data2, mask_bit);

   modport regfile (input  rd_addr1, rd_addr2, mask_addr,
                    output rd_data1, rd_data2, mask_bit);

endinterface

// Write-back from execute, retire also feeds the scoreboard
interface lane_wb_if import lane_cfg_pkg::*; ();

   logic                  wr_en;
   logic [REG_ADDR_W-1:0] wr_addr;
   logic [BE_W-1:0]       wr_be;
   logic [DATA_W-1:0]     wr_data;
   logic                  mask_wen;
   logic                  mask_data;
   logic                  retire;

   modport exec (output wr_en, wr_addr, wr_be, wr_data, mask_wen, mask_data, retire);

   modport regfile (input wr_en, wr_addr, wr_be, wr_data, mask_wen, mask_data);

   modport fetch (input retire, wr_addr);

endinterface

`default_nettype wire

// File: source/lane_isa_pkg.sv
`default_nettype none

package lane_isa_pkg;
   import lane_cfg_pkg::*;

   // Lane operations
   typedef enum logic [2:0] {
      OP_ADD   = 3'd0,
      OP_SUB   = 3'd1,
      OP_AND   = 3'd2,
      OP_OR    = 3'd3,
      OP_XOR   = 3'd4,
      OP_MSEQ  = 3'd5,
      OP_LOAD  = 3'd6,
      OP_STORE = 3'd7
   } lane_op_e;

   // Element width, encoding 3 is illegal
   typedef enum logic [1:0] {
      SEW8  = 2'd0,
      SEW16 = 2'd1,
      SEW32 = 2'd2
   } sew_e;

   // Micro-op as seen at the issue port
   typedef struct packed {
      lane_op_e              op;
      sew_e                  sew;
      logic [REG_ADDR_W-1:0] vd;
      logic [REG_ADDR_W-1:0] vs1;
      logic [REG_ADDR_W-1:0] vs2;
      logic [EL_W-1:0]       el;
      logic                  masked;
      logic [DATA_W-1:0]     ld_data;
   } uop_t;

   // Operands already read and extracted, ready for execute
   typedef struct packed {
      lane_op_e              op;
      sew_e                  sew;
      logic [REG_ADDR_W-1:0] vd;
      logic [EL_W-1:0]       el;
      logic                  masked;
      logic                  mask_bit;
      logic [DATA_W-1:0]     a;
      logic [DATA_W-1:0]     b;
      logic [DATA_W-1:0]     ld_data;
   } opnd_entry_t;

endpackage

`default_nettype wire

// File: source/lane_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lane_regfile import lane_cfg_pkg::*; (
   input  logic      clk_i,
   lane_rd_if.regfile rd,
   lane_wb_if.regfile wb
);

   // Vector words and one mask bit per register
   logic [DATA_W-1:0] vreg_mem [NUM_REGS];
   logic [NUM_REGS-1:0] mask_mem;

   //////////////////////////////////////////////////
   // Write side
   //////////////////////////////////////////////////

   // Byte lanes are written independently
   always_ff @(posedge clk_i) begin
      for (int i = 0; i < BE_W; i++) begin
         if (wb.wr_en && wb.wr_be[i]) begin
            vreg_mem[wb.wr_addr][i*8 +: 8] <= wb.wr_data[i*8 +: 8];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wb.mask_wen) begin
         mask_mem[wb.wr_addr] <= wb.mask_data;
      end
   end

   //////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////

   // Registered reads return old data on a same-edge write
   always_ff @(posedge clk_i) begin
      rd.rd_data1 <= vreg_mem[rd.rd_addr1];
      rd.rd_data2 <= vreg_mem[rd.rd_addr2];
      rd.mask_bit <= mask_mem[rd.mask_addr];
   end

   // Execute must never hand over unknown write data
   a_wr_data_known : assert property (
      @(posedge clk_i) wb.wr_en |-> !$isunknown(wb.wr_data)
   ) else $error("register write with unknown data at v%0d", wb.wr_addr);

endmodule

`default_nettype wire

// File: source/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch import lane_cfg_pkg::*; import lane_isa_pkg::*; #(
   parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            issue_valid_i,
   input  uop_t                            issue_uop_i,
   output logic                            issue_ready_o,
   lane_rd_if.fetch                        rd,
   lane_wb_if.fetch                        wb,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0] free_slots_i,
   output logic                            push_o,
   output opnd_entry_t                     push_entry_o
);

   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [NUM_REGS-1:0] busy;
   logic                accept;
   logic                inflight_valid;
   uop_t                inflight_uop;
   logic                slots_ok;

   // Pick one element out of a word, zero-extended
   function automatic logic [DATA_W-1:0] extract_el(input logic [DATA_W-1:0] word,
                                                    input sew_e              sew,
                                                    input logic [EL_W-1:0]   el);
      logic [DATA_W-1:0] res;
      res = '0;
      case (sew)
         SEW8:    res[7:0]  = word[el*8 +: 8];
         SEW16:   res[15:0] = word[el[0]*16 +: 16];
         SEW32:   res       = word;
         default: res       = '0;
      endcase
      return res;
   endfunction

   //////////////////////////////////////////////////
   // Issue control
   //////////////////////////////////////////////////

   // Room for the uop in flight plus the new one
   assign slots_ok = free_slots_i > CNT_W'(inflight_valid);

   assign issue_ready_o = slots_ok &&
                          !busy[issue_uop_i.vd] &&
                          !busy[issue_uop_i.vs1] &&
                          !busy[issue_uop_i.vs2];

   assign accept = issue_valid_i && issue_ready_o;

   // Read addresses come straight from the issue port
   assign rd.rd_addr1  = issue_uop_i.vs1;
   assign rd.rd_addr2  = issue_uop_i.vs2;
   assign rd.mask_addr = issue_uop_i.vd;

   // Scoreboard, clear on the edge that ends the retire cycle
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         busy           <= '0;
         inflight_valid <= 1'b0;
      end else begin
         inflight_valid <= accept;
         if (wb.retire) begin
            busy[wb.wr_addr] <= 1'b0;
         end
         if (accept && issue_uop_i.op != OP_STORE) begin
            busy[issue_uop_i.vd] <= 1'b1;
         end
      end
   end

   // Uop fields held across the read cycle
   always_ff @(posedge clk_i) begin
      if (accept) begin
         inflight_uop <= issue_uop_i;
      end
   end

   //////////////////////////////////////////////////
   // Element extraction and push
   //////////////////////////////////////////////////

   assign push_o = inflight_valid;

   always_comb begin
      push_entry_o.op       = inflight_uop.op;
      push_entry_o.sew      = inflight_uop.sew;
      push_entry_o.vd       = inflight_uop.vd;
      push_entry_o.el       = inflight_uop.el;
      push_entry_o.masked   = inflight_uop.masked;
      push_entry_o.mask_bit = rd.mask_bit;
      push_entry_o.a        = extract_el(rd.rd_data1, inflight_uop.sew, inflight_uop.el);
      push_entry_o.b        = extract_el(rd.rd_data2, inflight_uop.sew, inflight_uop.el);
      push_entry_o.ld_data  = inflight_uop.ld_data;
   end

   a_no_illegal_sew : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      accept |-> (issue_uop_i.sew != 2'd3)
   ) else $error("uop issued with illegal SEW encoding");

endmodule

`default_nettype wire

// File: source/operand_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fifo import lane_cfg_pkg::*; import lane_isa_pkg::*; #(
   parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            push_i,
   input  opnd_entry_t                     push_entry_i,
   output logic [$clog2(FIFO_DEPTH+1)-1:0] free_slots_o,
   output logic                            head_valid_o,
   output opnd_entry_t                     head_entry_o,
   input  logic                            pop_i
);

   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   opnd_entry_t      entry_mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // Pointer advance with wrap for any depth
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop_i) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         entry_mem[wr_ptr] <= push_entry_i;
      end
   end

   assign head_valid_o = (count != '0);
   assign head_entry_o = entry_mem[rd_ptr];
   assign free_slots_o = CNT_W'(FIFO_DEPTH) - count;

   // Fetch and execute both have to respect the occupancy
   a_no_overflow : assert property (
      @(posedge clk_i) disable iff (!rst_i) push_i |-> (count != CNT_W'(FIFO_DEPTH))
   ) else $error("operand FIFO push while full");

   a_no_underflow : assert property (
      @(posedge clk_i) disable iff (!rst_i) pop_i |-> (count != '0)
   ) else $error("operand FIFO pop while empty");

endmodule

`default_nettype wire

// File: source/vector_lane_top.sv
`timescale 1ns/1ps
`default_nettype none

module vector_lane_top import lane_cfg_pkg::*; import lane_isa_pkg::*; #(
   parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // Issue port
   input  logic                  issue_valid_i,
   output logic                  issue_ready_o,
   input  lane_op_e              issue_op_i,
   input  sew_e                  issue_sew_i,
   input  logic [REG_ADDR_W-1:0] issue_vd_i,
   input  logic [REG_ADDR_W-1:0] issue_vs1_i,
   input  logic [REG_ADDR_W-1:0] issue_vs2_i,
   input  logic [EL_W-1:0]       issue_el_i,
   input  logic                  issue_masked_i,
   input  logic [DATA_W-1:0]     issue_data_i,
   // Store port
   output logic                  store_valid_o,
   input  logic                  store_ready_i,
   output logic [DATA_W-1:0]     store_data_o
);

   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   uop_t             issue_uop;
   logic             push;
   opnd_entry_t      push_entry;
   logic [CNT_W-1:0] free_slots;
   logic             head_valid;
   opnd_entry_t      head_entry;
   logic             pop;

   lane_rd_if rd_bus ();
   lane_wb_if wb_bus ();

   // Pack the issue fields
   assign issue_uop.op      = issue_op_i;
   assign issue_uop.sew     = issue_sew_i;
   assign issue_uop.vd      = issue_vd_i;
   assign issue_uop.vs1     = issue_vs1_i;
   assign issue_uop.vs2     = issue_vs2_i;
   assign issue_uop.el      = issue_el_i;
   assign issue_uop.masked  = issue_masked_i;
   assign issue_uop.ld_data = issue_data_i;

   lane_regfile u_regfile (
      .clk_i (clk_i),
      .rd    (rd_bus),
      .wb    (wb_bus)
   );

   operand_fetch #(.FIFO_DEPTH(FIFO_DEPTH)) u_fetch (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .issue_valid_i (issue_valid_i),
      .issue_uop_i   (issue_uop),
      .issue_ready_o (issue_ready_o),
      .rd            (rd_bus),
      .wb            (wb_bus),
      .free_slots_i  (free_slots),
      .push_o        (push),
      .push_entry_o  (push_entry)
   );

   operand_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .push_i       (push),
      .push_entry_i (push_entry),
      .free_slots_o (free_slots),
      .head_valid_o (head_valid),
      .head_entry_o (head_entry),
      .pop_i        (pop)
   );

   execute_wb u_exec (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .head_valid_i  (head_valid),
      .head_entry_i  (head_entry),
      .pop_o         (pop),
      .wb            (wb_bus),
      .store_valid_o (store_valid_o),
      .store_data_o  (store_data_o),
      .store_ready_i (store_ready_i)
   );

endmodule

`default_nettype wire

// File: src.f
+incdir+verification
source/lane_cfg_pkg.sv
source/lane_isa_pkg.sv
source/lane_ifs.sv
source/lane_regfile.sv
source/operand_fetch.sv
source/operand_fifo.sv
source/execute_wb.sv
source/vector_lane_top.sv
verification/tb_vector_lane.sv

// File: verification/lane_model.svh
`ifndef LANE_MODEL_SVH
`define LANE_MODEL_SVH

// Register and mask state in issue order
logic [DATA_W-1:0] model_regs [NUM_REGS];
logic              model_mask [NUM_REGS];
logic [DATA_W-1:0] exp_store_q [$];
string             exp_name_q [$];

// Element size and position counted in bytes
function automatic int elem_nbytes(input sew_e sew);
   case (sew)
      SEW8:    return 1;
      SEW16:   return 2;
      default: return 4;
   endcase
endfunction

function automatic int elem_first_byte(input sew_e sew, input logic [EL_W-1:0] el);
   return (int'(el) * elem_nbytes(sew)) % BE_W;
endfunction

function automatic logic [DATA_W-1:0] read_elem(input logic [DATA_W-1:0] word,
                                                input sew_e              sew,
                                                input logic [EL_W-1:0]   el);
   logic [DATA_W-1:0] val;
   int                lo;
   val = '0;
   lo  = elem_first_byte(sew, el);
   for (int i = 0; i < elem_nbytes(sew); i++) begin
      val[i*8 +: 8] = word[(lo + i)*8 +: 8];
   end
   return val;
endfunction

// Only the bytes of the target element change
function automatic logic [DATA_W-1:0] write_elem(input logic [DATA_W-1:0] word,
                                                 input sew_e              sew,
                                                 input logic [EL_W-1:0]   el,
                                                 input logic [DATA_W-1:0] val);
   logic [DATA_W-1:0] res;
   int                lo;
   res = word;
   lo  = elem_first_byte(sew, el);
   for (int i = 0; i < elem_nbytes(sew); i++) begin
      res[(lo + i)*8 +: 8] = val[i*8 +: 8];
   end
   return res;
endfunction

task automatic model_apply(input uop_t u, input string name);
   logic [DATA_W-1:0] a;
   logic [DATA_W-1:0] b;
   logic [DATA_W-1:0] res;
   logic              en;
   a  = read_elem(model_regs[u.vs1], u.sew, u.el);
   b  = read_elem(model_regs[u.vs2], u.sew, u.el);
   en = !u.masked || model_mask[u.vd];
   case (u.op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_LOAD: res = u.ld_data;
      default: res = '0;
   endcase
   if (u.op == OP_STORE) begin
      exp_store_q.push_back(b);
      exp_name_q.push_back(name);
   end else if (u.op == OP_MSEQ) begin
      if (en) begin
         model_mask[u.vd] = (a == b);
      end
   end else if (en) begin
      model_regs[u.vd] = write_elem(model_regs[u.vd], u.sew, u.el, res);
   end
endtask

task automatic check_store(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
   checks++;
   if (act !== exp) begin
      value_errs++;
      $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
   end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
   checks++;
   if (act !== exp) begin
      value_errs++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
   end
endtask

`endif

// File: verification/tb_vector_lane.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vector_lane import lane_cfg_pkg::*; import lane_isa_pkg::*; ();

   // Stream layout in issue order
   localparam int N_RAND      = 400;
   localparam int FIRST_RAND  = 3 * NUM_REGS;
   localparam int FINAL_READ  = FIRST_RAND + N_RAND;
   localparam int TOTAL_UOPS  = FINAL_READ + NUM_REGS;
   localparam int BURST_AT    = FIRST_RAND + 200;
   localparam int BURST_LEN   = 40;
   localparam int CYCLE_LIMIT = 10 * (TOTAL_UOPS + 64) + 100;

   logic                  clk_i = 1'b0;
   logic                  rst_i;
   logic                  issue_valid_i;
   logic                  issue_ready_o;
   lane_op_e              issue_op_i;
   sew_e                  issue_sew_i;
   logic [REG_ADDR_W-1:0] issue_vd_i;
   logic [REG_ADDR_W-1:0] issue_vs1_i;
   logic [REG_ADDR_W-1:0] issue_vs2_i;
   logic [EL_W-1:0]       issue_el_i;
   logic                  issue_masked_i;
   logic [DATA_W-1:0]     issue_data_i;
   logic                  store_valid_o;
   logic                  store_ready_i;
   logic [DATA_W-1:0]     store_data_o;

   int                checks        = 0;
   int                value_errs    = 0;
   int                other_errs    = 0;
   int                issued        = 0;
   int                cycles        = 0;
   int                reset_edges   = 0;
   int                burst_left    = 0;
   logic              store_issued  = 1'b0;
   logic              saw_stall     = 1'b0;
   logic              prev_stall    = 1'b0;
   logic              ready_checked = 1'b0;
   logic [31:0]       rng_state     = 32'd54;
   uop_t              cur_uop;
   string             cur_name;

   `include "lane_model.svh"

   vector_lane_top #(.FIFO_DEPTH(DEF_FIFO_DEPTH)) uut (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .issue_valid_i  (issue_valid_i),
      .issue_ready_o  (issue_ready_o),
      .issue_op_i     (issue_op_i),
      .issue_sew_i    (issue_sew_i),
      .issue_vd_i     (issue_vd_i),
      .issue_vs1_i    (issue_vs1_i),
      .issue_vs2_i    (issue_vs2_i),
      .issue_el_i     (issue_el_i),
      .issue_masked_i (issue_masked_i),
      .issue_data_i   (issue_data_i),
      .store_valid_o  (store_valid_o),
      .store_ready_i  (store_ready_i),
      .store_data_o   (store_data_o)
   );

   always #2 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic string phase_of(input int idx);
      if (idx < NUM_REGS) return "init load";
      if (idx < 2 * NUM_REGS) return "readback";
      if (idx < FIRST_RAND) return "mask init";
      if (idx < FINAL_READ) return (burst_left > 0) ? "back-pressure" : "random ops";
      return "final readback";
   endfunction

   //////////////////////////////////////////////////
   // Stimulus generation
   //////////////////////////////////////////////////

   function automatic uop_t make_uop(input int idx);
      uop_t        u;
      logic [31:0] r;
      r = next_rand();
      u = '0;
      u.sew = SEW32;
      u.ld_data = next_rand();
      if (idx < NUM_REGS) begin
         u.op  = OP_LOAD;
         u.vd  = REG_ADDR_W'(idx);
         u.vs1 = u.vd;
         u.vs2 = u.vd;
      end else if (idx < 2 * NUM_REGS || idx >= FINAL_READ) begin
         u.op  = OP_STORE;
         u.vs2 = REG_ADDR_W'(idx % NUM_REGS);
         u.vs1 = u.vs2;
         u.vd  = u.vs2;
      end else if (idx < FIRST_RAND) begin
         // Self compares give a mix of set and clear mask bits
         u.op  = OP_MSEQ;
         u.vd  = REG_ADDR_W'(idx - 2 * NUM_REGS);
         u.vs1 = r[4:0];
         u.vs2 = r[5] ? r[4:0] : r[10:6];
      end else begin
         u.op     = (burst_left > 0) ? OP_STORE : lane_op_e'(r[2:0]);
         u.sew    = sew_e'((r[4:3] == 2'd3) ? 2'd2 : r[4:3]);
         u.vd     = r[9:5];
         u.vs1    = r[14:10];
         u.vs2    = r[19:15];
         u.el     = r[21:20];
         u.masked = r[22];
         // Narrow register pool for dependent chains
         if (r[23]) begin
            u.vd  = u.vd & REG_ADDR_W'(7);
            u.vs1 = u.vs1 & REG_ADDR_W'(7);
            u.vs2 = u.vs2 & REG_ADDR_W'(7);
         end
      end
      return u;
   endfunction

   task automatic drive_uop(input uop_t u);
      issue_valid_i  <= 1'b1;
      issue_op_i     <= u.op;
      issue_sew_i    <= u.sew;
      issue_vd_i     <= u.vd;
      issue_vs1_i    <= u.vs1;
      issue_vs2_i    <= u.vs2;
      issue_el_i     <= u.el;
      issue_masked_i <= u.masked;
      issue_data_i   <= u.ld_data;
   endtask

   task automatic print_counts();
      $display("Checks run: %0d, value errors: %0d, other errors: %0d",
               checks, value_errs, other_errs);
   endtask

   //////////////////////////////////////////////////
   // Drive, monitor and model update per edge
   //////////////////////////////////////////////////

   always @(posedge clk_i) begin
      logic accepted;
      if (!rst_i) begin
         reset_edges++;
         if (reset_edges > 1) check_flag("store_valid low in reset", 1'b0, store_valid_o);
      end else begin
         if (!ready_checked) begin
            check_flag("issue_ready after reset", 1'b1, issue_ready_o);
            ready_checked = 1'b1;
         end
         if (!store_issued) check_flag("store_valid before first store", 1'b0, store_valid_o);
         // Stalled store keeps valid high
         if (prev_stall) begin
            check_flag("store_valid held", 1'b1, store_valid_o);
         end
         prev_stall = store_valid_o && !store_ready_i;
         // While stalled the port shows the oldest expected store
         if (prev_stall && exp_store_q.size() != 0) begin
            check_store("stalled store data", exp_store_q[0], store_data_o);
         end
         if (store_valid_o && store_ready_i) begin
            if (exp_store_q.size() == 0) begin
               other_errs++;
               $display("ERROR: store of %08h arrived with no store outstanding", store_data_o);
            end else begin
               check_store(exp_name_q.pop_front(), exp_store_q.pop_front(), store_data_o);
            end
         end
         if (burst_left > 0 && issue_valid_i && !issue_ready_o) saw_stall = 1'b1;

         accepted = issue_valid_i && issue_ready_o;
         if (accepted) begin
            model_apply(cur_uop, $sformatf("%s uop %0d", cur_name, issued));
            if (cur_uop.op == OP_STORE) store_issued = 1'b1;
            issued++;
            if (issued == BURST_AT) burst_left = BURST_LEN;
         end
         if (!issue_valid_i || accepted) begin
            if (issued < TOTAL_UOPS) begin
               cur_name = phase_of(issued);
               cur_uop  = make_uop(issued);
               drive_uop(cur_uop);
            end else begin
               issue_valid_i <= 1'b0;
            end
         end

         // Store consumer is about 60% ready outside the burst
         if (burst_left > 0) begin
            store_ready_i <= 1'b0;
            burst_left--;
         end else begin
            store_ready_i <= (next_rand() % 100) < 60;
         end
      end
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles: %0d of %0d uops issued, %0d stores still expected",
                  cycles, issued, TOTAL_UOPS, exp_store_q.size());
         print_counts();
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      rst_i          <= 1'b0;
      issue_valid_i  <= 1'b0;
      issue_op_i     <= OP_ADD;
      issue_sew_i    <= SEW32;
      issue_vd_i     <= '0;
      issue_vs1_i    <= '0;
      issue_vs2_i    <= '0;
      issue_el_i     <= '0;
      issue_masked_i <= 1'b0;
      issue_data_i   <= '0;
      store_ready_i  <= 1'b0;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b1;
      while (!(issued == TOTAL_UOPS && exp_store_q.size() == 0)) @(posedge clk_i);
      // A few more edges to catch extra stores
      repeat (8) @(posedge clk_i);
      check_flag("issue stall during store back-pressure", 1'b1, saw_stall);
      print_counts();
      if (value_errs + other_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
